// ==== source/icache_pkg.sv ====
package icache_pkg;

	// Byte address from the core, 26 bits on this MIPS-style core
	localparam int ADDR_WIDTH = 26;
	// One instruction word
	localparam int DATA_WIDTH = 32;

	// 64 lines of 4 words, 1 KB in total
	localparam int INDEX_WIDTH = 6;
	localparam int OFFSET_WIDTH = 2;

	// Whatever is left above index, word offset and byte offset
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;

	localparam int LINE_WORDS = 1 << OFFSET_WIDTH;
	localparam int DEPTH = 1 << INDEX_WIDTH;

	// Field view of a fetch address, MSB first
	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		logic [INDEX_WIDTH-1:0] index;
		logic [OFFSET_WIDTH-1:0] offset;
		// Always zero for aligned fetches
		logic [1:0] byte_off;
	} fetch_fields_t;

	// Same 26 bits seen either as a flat address or as cache fields
	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		fetch_fields_t f;
	} fetch_addr_u;

endpackage

// ==== source/icache_fill_ifc.sv ====
interface icache_fill_ifc;

	// One write strobe per data bank, at most one set per beat
	logic [icache_pkg::LINE_WORDS-1:0] data_we;
	// Last beat of a line, also marks the line valid
	logic tag_we;
	// Line under refill
	logic [icache_pkg::INDEX_WIDTH-1:0] fill_index;
	// Beat straight from memory
	logic [icache_pkg::DATA_WIDTH-1:0] fill_word;
	logic [icache_pkg::TAG_WIDTH-1:0] fill_tag;

	// Refill controller side
	modport refill (
		output data_we, tag_we, fill_index, fill_word, fill_tag
	);

	// Lookup stage side, owns the banks
	modport banks (
		input data_we, tag_we, fill_index, fill_word, fill_tag
	);

endinterface

// ==== source/cache_bank.sv ====
module cache_bank #(
	parameter int WIDTH = 32,
	parameter int DEPTH_LOG2 = 6
) (
	input  logic clk,
	input  logic i_we,
	input  logic [DEPTH_LOG2-1:0] i_waddr,
	input  logic [WIDTH-1:0] i_wdata,
	input  logic [DEPTH_LOG2-1:0] i_raddr,
	output logic [WIDTH-1:0] o_rdata
);

	// Storage array, one entry per line
	logic [WIDTH-1:0] mem [1 << DEPTH_LOG2];

	// Single write port
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Registered read
	// Write-first on a same-address collision
	// so the fetch right after a refill already sees the new line
	always_ff @(posedge clk) begin
		if (i_we && (i_waddr == i_raddr)) begin
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[i_raddr];
		end
	end

endmodule

// ==== source/icache_lookup.sv ====
module icache_lookup (
	input  logic clk,
	input  logic rst_n,
	input  icache_pkg::fetch_addr_u i_pc_next,
	icache_fill_ifc.banks fill,
	input  logic i_busy,
	output icache_pkg::fetch_addr_u o_pc,
	output logic o_miss,
	output logic o_valid,
	output logic [icache_pkg::DATA_WIDTH-1:0] o_data
);

	// Address of the fetch now in the compare stage
	icache_pkg::fetch_addr_u pc_q;
	// One valid bit per line
	logic [icache_pkg::DEPTH-1:0] valid_bits;
	// Bank outputs, already aligned with pc_q
	logic [icache_pkg::TAG_WIDTH-1:0] tag_rd;
	logic [icache_pkg::DATA_WIDTH-1:0] word_rd [icache_pkg::LINE_WORDS];
	logic hit;

	// Tag store
	cache_bank #(
		.WIDTH      (icache_pkg::TAG_WIDTH),
		.DEPTH_LOG2 (icache_pkg::INDEX_WIDTH)
	) tag_bank (
		.clk,
		.i_we    (fill.tag_we),
		.i_waddr (fill.fill_index),
		.i_wdata (fill.fill_tag),
		.i_raddr (i_pc_next.f.index),
		.o_rdata (tag_rd)
	);

	// One bank per word of the line
	// all read in parallel, offset picks one later
	for (genvar g = 0; g < icache_pkg::LINE_WORDS; g++) begin : g_data
		cache_bank #(
			.WIDTH      (icache_pkg::DATA_WIDTH),
			.DEPTH_LOG2 (icache_pkg::INDEX_WIDTH)
		) data_bank (
			.clk,
			.i_we    (fill.data_we[g]),
			.i_waddr (fill.fill_index),
			.i_wdata (fill.fill_word),
			.i_raddr (i_pc_next.f.index),
			.o_rdata (word_rd[g])
		);
	end

	// Address register runs on the same edge as the bank reads
	// Core holds i_pc_next during a stall, so pc_q holds too
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= '0;
			valid_bits <= '0;
		end else begin
			pc_q <= i_pc_next;
			// Line becomes valid with its tag, on the last beat
			if (fill.tag_we) begin
				valid_bits[fill.fill_index] <= 1'b1;
			end
		end
	end

	// Compare stage
	always_comb begin
		hit = valid_bits[pc_q.f.index] && (tag_rd == pc_q.f.tag);
		// Banks are half-written while a refill runs
		o_valid = hit && !i_busy;
		o_miss = !i_busy && !o_valid;
		o_data = word_rd[pc_q.f.offset];
		o_pc = pc_q;
	end

	// A hit never starts a refill
	a_hit_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid |=> !i_busy);

endmodule

// ==== source/icache_refill.sv ====
module icache_refill (
	input  logic clk,
	input  logic rst_n,
	input  logic i_miss,
	input  icache_pkg::fetch_addr_u i_pc,
	icache_fill_ifc.refill fill,
	output logic o_busy,
	output logic [icache_pkg::ADDR_WIDTH-1:0] o_mem_araddr,
	output logic o_mem_arvalid,
	input  logic i_mem_arready,
	input  logic i_mem_rvalid,
	input  logic [icache_pkg::DATA_WIDTH-1:0] i_mem_rdata
);

	enum logic [1:0] {
		// Idle, watching for a miss
		ST_READY,
		// Read address out, waiting for arready
		ST_REQUEST,
		// Taking beats into the banks
		ST_DATA
	} state, next_state;

	// Line-aligned address of the line being fetched
	icache_pkg::fetch_addr_u line_q;
	// One-hot pointer to the bank the next beat goes to
	logic [icache_pkg::LINE_WORDS-1:0] word_sel;
	logic beat;
	logic last_beat;

	always_comb begin
		beat = (state == ST_DATA) && i_mem_rvalid;
		// Beats arrive word 0 first, so the top bit marks the end
		last_beat = beat && word_sel[icache_pkg::LINE_WORDS-1];
	end

	// Next state
	always_comb begin
		next_state = state;
		unique case (state)
			ST_READY: begin
				if (i_miss) begin
					next_state = ST_REQUEST;
				end
			end
			ST_REQUEST: begin
				if (i_mem_arready) begin
					next_state = ST_DATA;
				end
			end
			ST_DATA: begin
				if (last_beat) begin
					next_state = ST_READY;
				end
			end
			default: next_state = ST_READY;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_READY;
			word_sel <= {{(icache_pkg::LINE_WORDS - 1){1'b0}}, 1'b1};
		end else begin
			state <= next_state;
			// Rotate on each beat, wraps back to word 0 after the line
			if (beat) begin
				word_sel <= {word_sel[icache_pkg::LINE_WORDS-2:0],
					word_sel[icache_pkg::LINE_WORDS-1]};
			end
		end
	end

	// Capture the missed line, offset and byte bits dropped
	always_ff @(posedge clk) begin
		if ((state == ST_READY) && i_miss) begin
			line_q.f.tag <= i_pc.f.tag;
			line_q.f.index <= i_pc.f.index;
			line_q.f.offset <= '0;
			line_q.f.byte_off <= '0;
		end
	end

	// Memory side and bank writes
	always_comb begin
		o_busy = (state != ST_READY);
		o_mem_arvalid = (state == ST_REQUEST);
		o_mem_araddr = line_q.raw;
		// Data beats always accepted, no ready back to memory
		fill.data_we = beat ? word_sel : '0;
		fill.tag_we = last_beat;
		fill.fill_index = line_q.f.index;
		fill.fill_word = i_mem_rdata;
		fill.fill_tag = line_q.f.tag;
	end

	// Request stays up and unchanged until the memory takes it
	a_araddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		o_mem_arvalid && !i_mem_arready |=> o_mem_arvalid && $stable(o_mem_araddr));

	// Memory only returns data for an accepted request
	a_rvalid_in_data: assert property (@(posedge clk) disable iff (!rst_n)
		i_mem_rvalid |-> state == ST_DATA);

endmodule

// ==== source/icache_top.sv ====
module icache_top (
	input  logic clk,
	input  logic rst_n,

	// Core fetch side
	input  logic [icache_pkg::ADDR_WIDTH-1:0] i_pc_next,
	output logic o_valid,
	output logic [icache_pkg::DATA_WIDTH-1:0] o_data,

	// Memory read-address channel
	output logic [icache_pkg::ADDR_WIDTH-1:0] o_mem_araddr,
	output logic o_mem_arvalid,
	input  logic i_mem_arready,

	// Memory read-data channel, cache is always ready
	input  logic i_mem_rvalid,
	input  logic [icache_pkg::DATA_WIDTH-1:0] i_mem_rdata
);

	// Raw core address, decoded into fields inside the lookup
	icache_pkg::fetch_addr_u pc_next;
	// Registered fetch address, handed to the refill on a miss
	icache_pkg::fetch_addr_u pc;
	logic miss;
	logic busy;

	// Bank write path from refill to lookup
	icache_fill_ifc fill ();

	assign pc_next.raw = i_pc_next;

	// Address stage and compare stage
	icache_lookup lookup0 (
		.clk,
		.rst_n,
		.i_pc_next (pc_next),
		.fill      (fill.banks),
		.i_busy    (busy),
		.o_pc      (pc),
		.o_miss    (miss),
		.o_valid,
		.o_data
	);

	// Line fetch from memory
	icache_refill refill0 (
		.clk,
		.rst_n,
		.i_miss        (miss),
		.i_pc          (pc),
		.fill          (fill.refill),
		.o_busy        (busy),
		.o_mem_araddr,
		.o_mem_arvalid,
		.i_mem_arready,
		.i_mem_rvalid,
		.i_mem_rdata
	);

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Low across the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== sim/mem_model.sv ====
module mem_model (
	input  logic clk,
	input  logic rst_n,
	input  logic [icache_pkg::ADDR_WIDTH-1:0] i_araddr,
	input  logic i_arvalid,
	output logic o_arready,
	output logic o_rvalid,
	output logic [icache_pkg::DATA_WIDTH-1:0] o_rdata,
	output logic [31:0] o_req_count,
	output logic [icache_pkg::ADDR_WIDTH-1:0] o_last_addr
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] rnd;
	// Next beat to send and how many are still owed
	logic [icache_pkg::ADDR_WIDTH-1:0] beat_addr;
	int beats_left;
	int remaining;
	logic [icache_pkg::ADDR_WIDTH-1:0] next_addr;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	initial begin
		o_arready = 1'b0;
		o_rvalid = 1'b0;
		o_rdata = '0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			rnd <= 32'd35;
			o_arready <= 1'b0;
			o_rvalid <= 1'b0;
			o_req_count <= '0;
			beats_left <= 0;
		end else begin
			rnd <= xorshift(rnd);
			if (beats_left == 0) begin
				if (i_arvalid && o_arready) begin
					// Request taken on this edge
					o_req_count <= o_req_count + 1;
					o_last_addr <= i_araddr;
					beat_addr <= i_araddr;
					beats_left <= icache_pkg::LINE_WORDS;
					o_arready <= 1'b0;
				end else begin
					// Ready on roughly one edge in four
					o_arready <= (rnd[1:0] == 2'b00);
				end
			end else begin
				// Beat showing at this edge has been taken
				remaining = beats_left - (o_rvalid ? 1 : 0);
				next_addr = o_rvalid ? beat_addr + 26'd4 : beat_addr;
				beats_left <= remaining;
				beat_addr <= next_addr;
				// Gap on roughly one edge in four
				o_rvalid <= (remaining != 0) && (rnd[3:2] != 2'b00);
				o_rdata <= (32'(next_addr) >> 2) ^ 32'hA5A50000;
			end
		end
	end

endmodule

// ==== sim/icache_tb.sv ====
module icache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int VALID_TIMEOUT = 200;
	localparam int RESET_TIMEOUT = 8;
	// Line at index 5 that stays resident to the end
	localparam logic [icache_pkg::ADDR_WIDTH-1:0] STREAM_BASE = 26'h0004850;

	logic clk;
	logic rst_n;
	logic [icache_pkg::ADDR_WIDTH-1:0] i_pc_next = '0;
	logic o_valid;
	logic [icache_pkg::DATA_WIDTH-1:0] o_data;
	logic [icache_pkg::ADDR_WIDTH-1:0] o_mem_araddr;
	logic o_mem_arvalid;
	logic i_mem_arready;
	logic i_mem_rvalid;
	logic [icache_pkg::DATA_WIDTH-1:0] i_mem_rdata;
	logic [31:0] req_count;
	logic [icache_pkg::ADDR_WIDTH-1:0] last_addr;
	// Request left pending in the previous cycle
	logic held = 1'b0;
	logic [icache_pkg::ADDR_WIDTH-1:0] held_addr;
	int expected_count = 0;
	int cycles;

	// Stimulus table with one row per fetch
	string names[$];
	logic [icache_pkg::ADDR_WIDTH-1:0] addrs[$];
	bit refills[$];
	// Reference tags and valid bits
	logic [icache_pkg::TAG_WIDTH-1:0] model_tag [icache_pkg::DEPTH];
	bit model_valid [icache_pkg::DEPTH];

	clk_gen clk_gen0 (.clk, .rst_n);

	icache_top dut0 (.*);

	mem_model mem0 (
		.clk,
		.rst_n,
		.i_araddr    (o_mem_araddr),
		.i_arvalid   (o_mem_arvalid),
		.o_arready   (i_mem_arready),
		.o_rvalid    (i_mem_rvalid),
		.o_rdata     (i_mem_rdata),
		.o_req_count (req_count),
		.o_last_addr (last_addr)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// Word address XOR a fixed pattern
	function automatic logic [31:0] expected_word(input logic [icache_pkg::ADDR_WIDTH-1:0] a);
		return (32'(a) >> 2) ^ 32'hA5A50000;
	endfunction

	// Append a row and run it through the reference tag store
	task automatic add_entry(input string name, input logic [icache_pkg::ADDR_WIDTH-1:0] a);
		logic [icache_pkg::INDEX_WIDTH-1:0] idx;
		logic [icache_pkg::TAG_WIDTH-1:0] tag;
		idx = a[icache_pkg::OFFSET_WIDTH+2 +: icache_pkg::INDEX_WIDTH];
		tag = a[icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH];
		names.push_back(name);
		addrs.push_back(a);
		refills.push_back(!model_valid[idx] || (model_tag[idx] != tag));
		model_valid[idx] = 1'b1;
		model_tag[idx] = tag;
	endtask

	// Pending read address has to hold until arready
	always @(negedge clk) begin
		if (rst_n && held) begin
			check_value("araddr_hold_valid", 1, o_mem_arvalid);
			check_value("araddr_hold", held_addr, o_mem_araddr);
		end
		held = o_mem_arvalid && !i_mem_arready;
		held_addr = o_mem_araddr;
	end

	initial begin
		// Registered pc resets to zero so the first fetch is line 0
		add_entry("reset_vector", 26'h0000000);
		add_entry("cold_miss", 26'h0004858);
		add_entry("same_line_w0", 26'h0004850);
		add_entry("same_line_w3", 26'h000485C);
		// Index 9 with two tags
		add_entry("conflict_a", 26'h0040090);
		add_entry("conflict_b", 26'h00A8094);
		add_entry("conflict_a2", 26'h0040098);
		add_entry("conflict_b2", 26'h00A809C);
		add_entry("revisit_idx5", 26'h0004854);
		add_entry("max_tag", 26'h3FFFFFC);
		add_entry("revisit_idx0", 26'h0000008);

		// Quiet outputs in reset and in the cycle after release
		cycles = 0;
		do begin
			if (cycles == RESET_TIMEOUT) begin
				report_timeout("reset release");
			end
			@(negedge clk);
			cycles++;
			check_value("reset_valid", 0, o_valid);
			check_value("reset_arvalid", 0, o_mem_arvalid);
		end while (!rst_n);

		foreach (names[k]) begin
			@(posedge clk);
			i_pc_next <= addrs[k];
			expected_count += refills[k];
			// Address now in the compare stage
			@(posedge clk);
			cycles = 0;
			do begin
				if (cycles == VALID_TIMEOUT) begin
					report_timeout({"o_valid in ", names[k]});
				end
				@(negedge clk);
				cycles++;
			end while (o_valid !== 1'b1);
			if (!refills[k]) begin
				check_value({names[k], "_latency"}, 1, cycles);
			end else begin
				// Offset and byte bits cleared
				check_value({names[k], "_araddr"}, addrs[k] & ~26'hF, last_addr);
			end
			check_value(names[k], expected_word(addrs[k]), o_data);
			check_value({names[k], "_requests"}, expected_count, req_count);
		end

		// Back to back over one line with a new address every cycle
		@(posedge clk);
		i_pc_next <= STREAM_BASE;
		for (int w = 1; w <= icache_pkg::LINE_WORDS; w++) begin
			@(posedge clk);
			if (w < icache_pkg::LINE_WORDS) begin
				i_pc_next <= STREAM_BASE + 26'(4 * w);
			end
			@(negedge clk);
			check_value($sformatf("stream_w%0d_valid", w - 1), 1, o_valid);
			check_value($sformatf("stream_w%0d", w - 1),
				expected_word(STREAM_BASE + 26'(4 * (w - 1))), o_data);
		end
		check_value("stream_requests", expected_count, req_count);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
source/icache_pkg.sv
source/icache_fill_ifc.sv
source/cache_bank.sv
source/icache_lookup.sv
source/icache_refill.sv
source/icache_top.sv
sim/clk_gen.sv
sim/mem_model.sv
sim/icache_tb.sv
